/* hdl/serv_pkg.sv */
package serv_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [4:0]  bit_idx_t;
   typedef logic [4:0]  opcode_t;         // Instruction bits 6..2
   typedef logic [1:0]  rd_src_t;
   typedef logic        alu_rd_sel_t;

   localparam opcode_t OP_OPIMM  = 5'b00100;
   localparam opcode_t OP_AUIPC  = 5'b00101;
   localparam opcode_t OP_OP     = 5'b01100;
   localparam opcode_t OP_LUI    = 5'b01101;
   localparam opcode_t OP_BRANCH = 5'b11000;
   localparam opcode_t OP_JALR   = 5'b11001;
   localparam opcode_t OP_JAL    = 5'b11011;

   localparam rd_src_t RD_SRC_ALU  = 2'd0;
   localparam rd_src_t RD_SRC_CTRL = 2'd1; // Link address or AUIPC sum
   localparam rd_src_t RD_SRC_IMM  = 2'd2;

   localparam alu_rd_sel_t ALU_RES_ADD = 1'b0;
   localparam alu_rd_sel_t ALU_RES_LT  = 1'b1;

   typedef enum logic [1:0] {
      IDLE,
      COMPARE,
      RUN
   } decode_state_e;

   localparam int WB_ADR_W = 8;

   // Debug register map, byte addresses
   localparam logic [WB_ADR_W-1:0] DBG_CTRL     = 8'h00;
   localparam logic [WB_ADR_W-1:0] DBG_PC       = 8'h04;
   localparam logic [WB_ADR_W-1:0] DBG_RETIRED  = 8'h08;
   localparam logic [WB_ADR_W-1:0] DBG_REG_BASE = 8'h80;

endpackage

/* hdl/serial_ifs.sv */
`timescale 1ns/1ps

interface alu_ctrl_if import serv_pkg::*; ();
   logic        en;                       // Serial phase active
   logic        init;                     // COMPARE phase
   logic        sub;
   logic        cmp_uns;
   logic        cmp_neg;
   alu_rd_sel_t rd_sel;
   logic        op_b_imm;
   logic        imm;                      // Immediate bit at the current index

   modport master (output en, init, sub, cmp_uns, cmp_neg, rd_sel, op_b_imm, imm);
   modport slave  (input  en, init, sub, cmp_uns, cmp_neg, rd_sel, op_b_imm, imm);
endinterface

interface rf_ctrl_if import serv_pkg::*; ();
   bit_idx_t  cnt;
   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   reg_addr_t rd_addr;
   logic      rd_en;
   logic      run;
   logic      last;                       // Final bit of RUN

   modport master (output cnt, rs1_addr, rs2_addr, rd_addr, rd_en, run, last);
   modport slave  (input  cnt, rs1_addr, rs2_addr, rd_addr, rd_en, run, last);
endinterface

/* hdl/serial_decode.sv */
`timescale 1ns/1ps

module serial_decode import serv_pkg::*; (
   input  logic       clk,
   input  logic       i_rst_n,
   input  word_t      i_ibus_dat,
   input  logic       i_ibus_vld,
   output logic       o_ibus_rdy,
   input  logic       i_halt,
   output rd_src_t    o_rd_src,
   output logic       o_retire,
   alu_ctrl_if.master alu,
   rf_ctrl_if.master  rf
);

   decode_state_e state;
   bit_idx_t      cnt;
   opcode_t       opcode;
   logic [2:0]    funct3;
   logic          is_op;
   logic          is_opimm;
   logic          is_branch;
   logic          is_jal;
   logic          is_jalr;
   logic          is_lui;
   logic          is_auipc;
   logic          known;
   logic          slt_op;
   logic          cmp_op;
   logic          go;
   logic          cnt_done;
   word_t         imm_i;
   word_t         imm_u;
   word_t         imm_b;
   word_t         imm_j;
   word_t         imm_w;

   // Instruction word is held by the fetch side for the whole instruction
   assign opcode = i_ibus_dat[6:2];
   assign funct3 = i_ibus_dat[14:12];

   assign is_op     = (opcode == OP_OP);
   assign is_opimm  = (opcode == OP_OPIMM);
   assign is_branch = (opcode == OP_BRANCH);
   assign is_jal    = (opcode == OP_JAL);
   assign is_jalr   = (opcode == OP_JALR);
   assign is_lui    = (opcode == OP_LUI);
   assign is_auipc  = (opcode == OP_AUIPC);
   assign known     = is_op | is_opimm | is_branch | is_jal | is_jalr | is_lui | is_auipc;

   assign slt_op = (is_op | is_opimm) & (funct3[2:1] == 2'b01);
   assign cmp_op = is_branch | slt_op;

   assign o_ibus_rdy = (state == IDLE) & ~i_halt;
   assign go         = i_ibus_vld & o_ibus_rdy;
   assign cnt_done   = (cnt == 5'd31);

   // Immediate words per format, serialized by the bit counter
   assign imm_i = {{20{i_ibus_dat[31]}}, i_ibus_dat[31:20]};
   assign imm_u = {i_ibus_dat[31:12], 12'b0};
   assign imm_b = {{19{i_ibus_dat[31]}}, i_ibus_dat[31], i_ibus_dat[7],
                   i_ibus_dat[30:25], i_ibus_dat[11:8], 1'b0};
   assign imm_j = {{11{i_ibus_dat[31]}}, i_ibus_dat[31], i_ibus_dat[19:12],
                   i_ibus_dat[20], i_ibus_dat[30:21], 1'b0};

   always_comb begin
      if (is_lui | is_auipc)
         imm_w = imm_u;
      else if (is_branch)
         imm_w = imm_b;
      else if (is_jal)
         imm_w = imm_j;
      else
         imm_w = imm_i;                   // OP-IMM, JALR and unknown opcodes
   end

   always_comb begin
      if (is_jal | is_jalr | is_auipc)
         o_rd_src = RD_SRC_CTRL;
      else if (is_lui)
         o_rd_src = RD_SRC_IMM;
      else
         o_rd_src = RD_SRC_ALU;
   end

   assign alu.en       = (state != IDLE);
   assign alu.init     = (state == COMPARE);
   assign alu.sub      = cmp_op | (is_op & (funct3 == 3'b000) & i_ibus_dat[30]);
   assign alu.cmp_uns  = is_branch ? funct3[1] : funct3[0];
   assign alu.cmp_neg  = is_branch & funct3[0];  // BNE, BGE, BGEU
   // LT flag for SLT* and ordered branches, equality flag for BEQ/BNE
   assign alu.rd_sel   = (slt_op | (is_branch & funct3[2])) ? ALU_RES_LT : ALU_RES_ADD;
   assign alu.op_b_imm = ~(is_op | is_branch);
   assign alu.imm      = imm_w[cnt];

   assign rf.cnt      = cnt;
   assign rf.rs1_addr = i_ibus_dat[19:15];
   assign rf.rs2_addr = i_ibus_dat[24:20];
   assign rf.rd_addr  = i_ibus_dat[11:7];
   assign rf.rd_en    = known & ~is_branch & (rf.rd_addr != '0);
   assign rf.run      = (state == RUN);
   assign rf.last     = rf.run & cnt_done;

   assign o_retire = rf.last;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state <= IDLE;
         cnt   <= '0;
      end else begin
         cnt <= alu.en ? cnt + 5'd1 : '0;
         case (state)
            IDLE: begin
               if (go)
                  state <= cmp_op ? COMPARE : RUN;
            end
            COMPARE: begin
               if (cnt_done)
                  state <= RUN;
            end
            RUN: begin
               if (cnt_done)
                  state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

/* hdl/serial_alu.sv */
`timescale 1ns/1ps

module serial_alu import serv_pkg::*; (
   input  logic      clk,
   input  logic      i_rst_n,
   alu_ctrl_if.slave ctl,
   input  bit_idx_t  i_cnt,
   input  logic      i_rs1,
   input  logic      i_rs2,
   output logic      o_cmp,
   output logic      o_rd
);

   logic op_b;
   logic b_inv;
   logic c_in;
   logic sum;
   logic c_out;
   logic carry_q;
   logic eq_q;
   logic lt_q;
   logic lt_bit;
   logic flag;

   assign op_b  = ctl.op_b_imm ? ctl.imm : i_rs2;
   assign b_inv = op_b ^ ctl.sub;
   assign c_in  = (i_cnt == '0) ? ctl.sub : carry_q;  // +1 of the two's complement
   assign sum   = i_rs1 ^ b_inv ^ c_in;
   assign c_out = (i_rs1 & b_inv) | (c_in & (i_rs1 ^ b_inv));

   // At bit 31: unsigned borrow, or signed result corrected for overflow
   assign lt_bit = ctl.cmp_uns ? ~c_out : ((i_rs1 ^ op_b) ? i_rs1 : sum);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         carry_q <= 1'b0;
         eq_q    <= 1'b0;
         lt_q    <= 1'b0;
      end else if (ctl.en) begin
         carry_q <= c_out;
         if (ctl.init) begin
            eq_q <= ~(i_rs1 ^ op_b) & (eq_q | (i_cnt == '0));
            if (i_cnt == 5'd31)
               lt_q <= lt_bit;
         end
      end
   end

   // Flags stay held through RUN
   assign flag  = (ctl.rd_sel == ALU_RES_LT) ? lt_q : eq_q;
   assign o_cmp = flag ^ ctl.cmp_neg;

   assign o_rd = (ctl.rd_sel == ALU_RES_ADD) ? sum : (o_cmp & (i_cnt == '0));

endmodule

/* hdl/serial_regfile.sv */
`timescale 1ns/1ps

module serial_regfile import serv_pkg::*; (
   input  logic       clk,
   input  logic       i_rst_n,
   rf_ctrl_if.slave   rf,
   input  logic       i_rd_bit,
   output logic       o_rs1,
   output logic       o_rs2,
   input  reg_addr_t  i_dbg_addr,
   output word_t      o_dbg_dat
);

   word_t regs [32];
   logic  wr_en;

   // x0 stays zero regardless of rd_en
   assign wr_en = rf.run & rf.rd_en & (rf.rd_addr != '0);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[rf.rd_addr][rf.cnt] <= i_rd_bit;
      end
   end

   // Old bit is read before the same bit is overwritten
   assign o_rs1 = regs[rf.rs1_addr][rf.cnt];
   assign o_rs2 = regs[rf.rs2_addr][rf.cnt];

   assign o_dbg_dat = regs[i_dbg_addr];

endmodule

/* hdl/serial_ctrl.sv */
`timescale 1ns/1ps

module serial_ctrl import serv_pkg::*; #(
   parameter word_t RESET_PC = '0
) (
   input  logic      clk,
   input  logic      i_rst_n,
   rf_ctrl_if.slave  rf,
   alu_ctrl_if.slave alu,
   input  opcode_t   i_opcode,
   input  logic      i_rs1,
   input  logic      i_cmp,
   output logic      o_rd_bit,
   output word_t     o_pc
);

   word_t pc_q;
   word_t npc_q;
   logic  first;
   logic  is_jalr;
   logic  jump;
   logic  pc_bit;
   logic  four_bit;
   logic  link_c_in;
   logic  link_sum;
   logic  link_c_q;
   logic  base;
   logic  tgt_c_in;
   logic  tgt_sum;
   logic  tgt_c_q;
   logic  tgt_bit;
   logic  next_bit;

   assign first   = (rf.cnt == '0);
   assign is_jalr = (i_opcode == OP_JALR);
   assign pc_bit  = pc_q[rf.cnt];

   // Link adder, PC + 4
   assign four_bit  = (rf.cnt == 5'd2);
   assign link_c_in = first ? 1'b0 : link_c_q;
   assign link_sum  = pc_bit ^ four_bit ^ link_c_in;

   // Target adder, base + imm
   assign base     = is_jalr ? i_rs1 : pc_bit;
   assign tgt_c_in = first ? 1'b0 : tgt_c_q;
   assign tgt_sum  = base ^ alu.imm ^ tgt_c_in;
   assign tgt_bit  = tgt_sum & ~(is_jalr & first);  // JALR drops bit 0

   assign jump     = (i_opcode == OP_JAL) | is_jalr | ((i_opcode == OP_BRANCH) & i_cmp);
   assign next_bit = jump ? tgt_bit : link_sum;

   assign o_rd_bit = (i_opcode == OP_AUIPC) ? tgt_sum : link_sum;

   always_ff @(posedge clk) begin
      if (rf.run) begin
         link_c_q <= (pc_bit & four_bit) | (link_c_in & (pc_bit ^ four_bit));
         tgt_c_q  <= (base & alu.imm) | (tgt_c_in & (base ^ alu.imm));
         npc_q    <= {next_bit, npc_q[31:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n)
         pc_q <= RESET_PC;
      else if (rf.last)
         pc_q <= {next_bit, npc_q[31:1]};
   end

   assign o_pc = pc_q;

endmodule

/* hdl/debug_wb_regs.sv */
`timescale 1ns/1ps

module debug_wb_regs import serv_pkg::*; (
   input  logic                clk,
   input  logic                i_rst_n,
   input  logic                i_wb_cyc,
   input  logic                i_wb_stb,
   input  logic                i_wb_we,
   input  logic [WB_ADR_W-1:0] i_wb_adr,
   input  word_t               i_wb_dat,
   output word_t               o_wb_dat,
   output logic                o_wb_ack,
   input  logic                i_retire,
   input  word_t               i_pc,
   output logic                o_halt,
   output reg_addr_t           o_reg_addr,
   input  word_t               i_reg_dat
);

   logic  req;
   logic  ack_q;
   logic  halt_q;
   word_t retired_q;
   word_t rdata;

   assign req = i_wb_cyc & i_wb_stb & ~ack_q;  // New request, no ack pending

   assign o_reg_addr = i_wb_adr[6:2];

   always_comb begin
      case (i_wb_adr)
         DBG_CTRL:    rdata = {31'b0, halt_q};
         DBG_PC:      rdata = i_pc;
         DBG_RETIRED: rdata = retired_q;
         default:     rdata = (i_wb_adr >= DBG_REG_BASE) ? i_reg_dat : '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         ack_q     <= 1'b0;
         halt_q    <= 1'b0;
         retired_q <= '0;
      end else begin
         ack_q <= req;
         if (req & i_wb_we & (i_wb_adr == DBG_CTRL))
            halt_q <= i_wb_dat[0];
         if (i_retire)
            retired_q <= retired_q + 32'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (req)
         o_wb_dat <= rdata;
   end

   assign o_wb_ack = ack_q;
   assign o_halt   = halt_q;

endmodule

/* hdl/serial_cpu_top.sv */
`timescale 1ns/1ps

module serial_cpu_top import serv_pkg::*; #(
   parameter word_t RESET_PC = '0
) (
   input  logic                clk,
   input  logic                i_rst_n,
   output word_t               o_ibus_adr,
   input  word_t               i_ibus_dat,
   input  logic                i_ibus_vld,
   output logic                o_ibus_rdy,
   input  logic                i_wb_cyc,
   input  logic                i_wb_stb,
   input  logic                i_wb_we,
   input  logic [WB_ADR_W-1:0] i_wb_adr,
   input  word_t               i_wb_dat,
   output word_t               o_wb_dat,
   output logic                o_wb_ack
);

   alu_ctrl_if alu_if ();
   rf_ctrl_if  rf_if ();

   rd_src_t   rd_src;
   opcode_t   opcode;
   logic      retire;
   logic      halt;
   logic      rs1_bit;
   logic      rs2_bit;
   logic      cmp;
   logic      alu_rd;
   logic      ctrl_rd;
   logic      rd_bit;
   reg_addr_t dbg_reg_addr;
   word_t     dbg_reg_dat;

   assign opcode = i_ibus_dat[6:2];

   // Write-back source for the destination bit
   assign rd_bit = (rd_src == RD_SRC_CTRL) ? ctrl_rd :
                   (rd_src == RD_SRC_IMM)  ? alu_if.imm : alu_rd;

   serial_decode u_decode (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_dat (i_ibus_dat),
      .i_ibus_vld (i_ibus_vld),
      .o_ibus_rdy (o_ibus_rdy),
      .i_halt     (halt),
      .o_rd_src   (rd_src),
      .o_retire   (retire),
      .alu        (alu_if.master),
      .rf         (rf_if.master)
   );

   serial_alu u_alu (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .ctl     (alu_if.slave),
      .i_cnt   (rf_if.cnt),
      .i_rs1   (rs1_bit),
      .i_rs2   (rs2_bit),
      .o_cmp   (cmp),
      .o_rd    (alu_rd)
   );

   serial_regfile u_regfile (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .rf         (rf_if.slave),
      .i_rd_bit   (rd_bit),
      .o_rs1      (rs1_bit),
      .o_rs2      (rs2_bit),
      .i_dbg_addr (dbg_reg_addr),
      .o_dbg_dat  (dbg_reg_dat)
   );

   serial_ctrl #(
      .RESET_PC (RESET_PC)
   ) u_ctrl (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .rf       (rf_if.slave),
      .alu      (alu_if.slave),
      .i_opcode (opcode),
      .i_rs1    (rs1_bit),
      .i_cmp    (cmp),
      .o_rd_bit (ctrl_rd),
      .o_pc     (o_ibus_adr)
   );

   debug_wb_regs u_debug (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_wb_cyc   (i_wb_cyc),
      .i_wb_stb   (i_wb_stb),
      .i_wb_we    (i_wb_we),
      .i_wb_adr   (i_wb_adr),
      .i_wb_dat   (i_wb_dat),
      .o_wb_dat   (o_wb_dat),
      .o_wb_ack   (o_wb_ack),
      .i_retire   (retire),
      .i_pc       (o_ibus_adr),
      .o_halt     (halt),
      .o_reg_addr (dbg_reg_addr),
      .i_reg_dat  (dbg_reg_dat)
   );

endmodule

/* dv/serial_cpu_sva.sv */
`timescale 1ns/1ps

module serial_cpu_sva import serv_pkg::*; (
   input logic          clk,
   input logic          i_rst_n,
   input logic          i_go,
   input logic          i_cmp_op,
   input logic          i_rdy,
   input decode_state_e i_state
);

   a_rdy_falls: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_go |=> !i_rdy)
      else $error("ready stayed high after an accept");

   // Plain instructions spend 32 cycles in RUN
   a_run_len: assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_go && !i_cmp_op) |=> ##31 (i_state == RUN) ##1 (i_state == IDLE))
      else $error("non-compare instruction did not take 32 cycles");

   a_cmp_len: assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_go && i_cmp_op) |=> ##31 (i_state == COMPARE) ##1 (i_state == RUN)
                             ##31 (i_state == RUN) ##1 (i_state == IDLE))
      else $error("compare instruction did not take 64 cycles");

   a_state_legal: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_state inside {IDLE, COMPARE, RUN})
      else $error("decoder state outside its encoding");

endmodule

bind serial_decode serial_cpu_sva u_sva (
   .clk      (clk),
   .i_rst_n  (i_rst_n),
   .i_go     (go),
   .i_cmp_op (cmp_op),
   .i_rdy    (o_ibus_rdy),
   .i_state  (state)
);

/* dv/tb_serial_cpu.sv */
`timescale 1ns/1ps

module tb_serial_cpu import serv_pkg::*; ();

   localparam word_t RESET_PC    = 32'h0000_1000;
   localparam int    ACK_TIMEOUT = 10;
   localparam int    RDY_TIMEOUT = 200;
   localparam int    LAT_TIMEOUT = 80;
   localparam int    POLL_LIMIT  = 40;

   logic                clk;
   logic                rst_n;
   word_t               ibus_adr;
   word_t               ibus_dat;
   logic                ibus_vld;
   logic                ibus_rdy;
   logic                wb_cyc;
   logic                wb_stb;
   logic                wb_we;
   logic [WB_ADR_W-1:0] wb_adr;
   word_t               wb_wdat;
   word_t               wb_rdat;
   logic                wb_ack;

   word_t mregs [32];                     // Reference register file
   word_t mpc;
   word_t mretired;
   word_t rng_state;

   serial_cpu_top #(
      .RESET_PC (RESET_PC)
   ) DUT (
      .clk        (clk),
      .i_rst_n    (rst_n),
      .o_ibus_adr (ibus_adr),
      .i_ibus_dat (ibus_dat),
      .i_ibus_vld (ibus_vld),
      .o_ibus_rdy (ibus_rdy),
      .i_wb_cyc   (wb_cyc),
      .i_wb_stb   (wb_stb),
      .i_wb_we    (wb_we),
      .i_wb_adr   (wb_adr),
      .i_wb_dat   (wb_wdat),
      .o_wb_dat   (wb_rdat),
      .o_wb_ack   (wb_ack)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic word_t xorshift32(input word_t s);
      word_t x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic word_t next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   task automatic stop_run();
      $display("Test failures found");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check(input word_t got, input word_t exp, input string msg);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
         stop_run();
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;                                 // Sample and drive just after the edge
   endtask

   task automatic wb_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                            input word_t wdat, output word_t rdat);
      int waited;
      waited  = 0;
      wb_cyc  = 1'b1;
      wb_stb  = 1'b1;
      wb_we   = we;
      wb_adr  = adr;
      wb_wdat = wdat;
      next_cycle();
      while (!wb_ack) begin
         waited++;
         if (waited > ACK_TIMEOUT) begin
            $display("Wishbone access to %h got no ack", adr);
            stop_run();
         end
         next_cycle();
      end
      check(32'(waited), 32'd0, "Wishbone ack latency");
      rdat   = wb_rdat;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      next_cycle();
      check(32'(wb_ack), 32'd0, "Wishbone ack held longer than one cycle");
   endtask

   function automatic logic needs_compare(input word_t ins);
      if (ins[6:0] == 7'b1100011)
         return 1'b1;
      return (ins[6:0] == 7'b0110011 || ins[6:0] == 7'b0010011) &&
             (ins[14:12] == 3'b010 || ins[14:12] == 3'b011);
   endfunction

   function automatic word_t random_instr();
      word_t      r;
      word_t      ins;
      logic [2:0] f3;
      r   = next_rand();
      ins = next_rand();                  // Random registers and immediates
      f3  = (r[5:4] == 2'd1) ? 3'b010 : (r[5:4] == 2'd2) ? 3'b011 : 3'b000;
      case (r[3:0])
         4'd0, 4'd1, 4'd2, 4'd3: begin
            ins[31:25] = (f3 == 3'b000 && r[6]) ? 7'b0100000 : 7'b0000000;
            ins[14:12] = f3;
            ins[6:0]   = 7'b0110011;
         end
         4'd4, 4'd5, 4'd6: begin
            ins[14:12] = f3;
            ins[6:0]   = 7'b0010011;
         end
         4'd7: ins[6:0] = 7'b0110111;
         4'd8: ins[6:0] = 7'b0010111;
         4'd9: ins[6:0] = 7'b1101111;
         4'd10: begin
            ins[14:12] = 3'b000;
            ins[6:0]   = 7'b1100111;
         end
         default: begin
            f3 = r[9:7];
            if (f3[2:1] == 2'b01)
               f3[2] = 1'b1;              // No branch encodings 010 and 011
            ins[14:12] = f3;
            ins[6:0]   = 7'b1100011;
         end
      endcase
      return ins;
   endfunction

   task automatic model_exec(input word_t ins);
      word_t a;
      word_t b;
      word_t imm_i;
      word_t res;
      word_t npc;
      logic  wr;
      logic  taken;
      a     = mregs[ins[19:15]];
      b     = mregs[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      res   = '0;
      npc   = mpc + 32'd4;
      wr    = 1'b1;
      taken = 1'b0;
      case (ins[6:0])
         7'b0110011: begin
            if (ins[14:12] == 3'b010)
               res = {31'b0, $signed(a) < $signed(b)};
            else if (ins[14:12] == 3'b011)
               res = {31'b0, a < b};
            else
               res = ins[30] ? a - b : a + b;
         end
         7'b0010011: begin
            if (ins[14:12] == 3'b010)
               res = {31'b0, $signed(a) < $signed(imm_i)};
            else if (ins[14:12] == 3'b011)
               res = {31'b0, a < imm_i};
            else
               res = a + imm_i;
         end
         7'b0110111: res = {ins[31:12], 12'b0};
         7'b0010111: res = mpc + {ins[31:12], 12'b0};
         7'b1101111: begin
            res = mpc + 32'd4;
            npc = mpc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
         end
         7'b1100111: begin
            res = mpc + 32'd4;
            npc = (a + imm_i) & ~32'd1;
         end
         7'b1100011: begin
            wr = 1'b0;
            case (ins[14:12])
               3'b000:  taken = (a == b);
               3'b001:  taken = (a != b);
               3'b100:  taken = $signed(a) < $signed(b);
               3'b101:  taken = $signed(a) >= $signed(b);
               3'b110:  taken = (a < b);
               default: taken = (a >= b);
            endcase
            if (taken)
               npc = mpc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
         end
         default: wr = 1'b0;
      endcase
      if (wr && ins[11:7] != 5'd0)
         mregs[ins[11:7]] = res;
      mpc      = npc;
      mretired = mretired + 32'd1;
   endtask

   task automatic start_instr(input word_t ins);
      int waited;
      waited = 0;
      while (!ibus_rdy) begin
         waited++;
         if (waited > RDY_TIMEOUT) begin
            $display("Fetch port never became ready");
            stop_run();
         end
         next_cycle();
      end
      check(ibus_adr, mpc, "fetch address differs from model PC");
      ibus_dat = ins;                     // Held until ready returns
      ibus_vld = 1'b1;
      next_cycle();
      check(32'(ibus_rdy), 32'd0, "ready still high after accept");
      ibus_vld = 1'b0;
   endtask

   task automatic finish_instr(input word_t ins);
      int lat;
      lat = 0;
      while (!ibus_rdy) begin
         next_cycle();
         lat++;
         if (lat > LAT_TIMEOUT) begin
            $display("Instruction %h never completed", ins);
            stop_run();
         end
      end
      check(32'(lat), needs_compare(ins) ? 32'd64 : 32'd32, "instruction latency");
   endtask

   task automatic run_burst(input int count);
      word_t ins;
      for (int n = 0; n < count; n++) begin
         ins = random_instr();
         start_instr(ins);
         finish_instr(ins);
         model_exec(ins);
      end
   endtask

   task automatic compare_state(input string tag);
      word_t d;
      for (int i = 0; i < 32; i++) begin
         wb_access(1'b0, DBG_REG_BASE + 8'(4 * i), '0, d);
         check(d, mregs[i], $sformatf("%s, register x%0d", tag, i));
      end
      wb_access(1'b0, DBG_PC, '0, d);
      check(d, mpc, $sformatf("%s, debug PC", tag));
      wb_access(1'b0, DBG_RETIRED, '0, d);
      check(d, mretired, $sformatf("%s, retired count", tag));
   endtask

   task automatic halt_mid_instruction();
      word_t ins;
      word_t d;
      int    polls;
      ins = random_instr();
      start_instr(ins);
      model_exec(ins);
      wb_access(1'b1, DBG_CTRL, 32'd1, d);
      polls = 0;
      wb_access(1'b0, DBG_RETIRED, '0, d);
      while (d != mretired) begin
         polls++;
         if (polls > POLL_LIMIT) begin
            $display("Instruction in flight at halt never retired");
            stop_run();
         end
         wb_access(1'b0, DBG_RETIRED, '0, d);
      end
      for (int i = 0; i < 100; i++) begin
         next_cycle();
         check(32'(ibus_rdy), 32'd0, "ready rose while halted");
      end
      compare_state("halted mid-instruction");
      wb_access(1'b1, DBG_CTRL, 32'd0, d);
   endtask

   initial begin
      word_t d;
      rst_n     = 1'b0;
      ibus_dat  = '0;
      ibus_vld  = 1'b0;
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      wb_we     = 1'b0;
      wb_adr    = '0;
      wb_wdat   = '0;
      rng_state = 32'h9f1e_411b;
      mpc       = RESET_PC;
      mretired  = '0;
      for (int i = 0; i < 32; i++) begin
         mregs[i] = '0;
      end
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;
      next_cycle();

      check(32'(ibus_rdy), 32'd1, "ready after reset");
      check(ibus_adr, RESET_PC, "fetch address after reset");
      check(32'(wb_ack), 32'd0, "Wishbone ack after reset");
      wb_access(1'b0, DBG_CTRL, '0, d);
      check(d, 32'd0, "halt bit after reset");
      wb_access(1'b0, 8'h0C, '0, d);
      check(d, 32'd0, "unmapped debug read");
      compare_state("after reset");

      run_burst(300);
      wb_access(1'b1, DBG_CTRL, 32'd1, d);
      check(32'(ibus_rdy), 32'd0, "ready with halt set");
      wb_access(1'b0, DBG_CTRL, '0, d);
      check(d, 32'd1, "halt bit readback");
      compare_state("after random burst");
      wb_access(1'b1, DBG_CTRL, 32'd0, d);

      run_burst(20);
      halt_mid_instruction();
      run_burst(50);                      // Resumes from the model PC
      wb_access(1'b1, DBG_CTRL, 32'd1, d);
      compare_state("end of run");

      $display("All tests passed!");
      $finish;
   end

endmodule

/* src.f */
hdl/serv_pkg.sv
hdl/serial_ifs.sv
hdl/serial_decode.sv
hdl/serial_alu.sv
hdl/serial_regfile.sv
hdl/serial_ctrl.sv
hdl/debug_wb_regs.sv
hdl/serial_cpu_top.sv
dv/serial_cpu_sva.sv
dv/tb_serial_cpu.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
      -f src.f --top-module tb_serial_cpu -o sim_tb; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
   exit 0
fi
exit 1
